/* verilog.f */
+incdir+.
rs_core_pkg.sv
rs_fetch.sv
rs_decode.sv
rs_regbank.sv
rs_exec_ctrl.sv
rs_execute.sv
rs_core.sv
tb_rs_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the rs_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_rs_core -o tb_rs_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_rs_core > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx '\*\*\* PASSED \*\*\*' sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see sim.log"
exit 1

/* tb_rs_asm.svh */
////////////////////////////////////////
// Encoders for the instructions the core runs
// Offsets are byte offsets, branch and jump offsets even
////////////////////////////////////////
`ifndef TB_RS_ASM_SVH
`define TB_RS_ASM_SVH

// R-type arithmetic
function automatic rs_core_pkg::word_t asm_r(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, rs_core_pkg::OPC_OP};
endfunction

function automatic rs_core_pkg::word_t asm_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, rs_core_pkg::OPC_OP_IMM};
endfunction

// Upper 20 bits of the constant
function automatic rs_core_pkg::word_t asm_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, rs_core_pkg::OPC_LUI};
endfunction

function automatic rs_core_pkg::word_t asm_lw(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, rs_core_pkg::OPC_LOAD};
endfunction

function automatic rs_core_pkg::word_t asm_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                              input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rs_core_pkg::OPC_STORE};
endfunction

// BEQ with f3 000, BNE with f3 001
function automatic rs_core_pkg::word_t asm_br(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rs_core_pkg::OPC_BRANCH};
endfunction

function automatic rs_core_pkg::word_t asm_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, rs_core_pkg::OPC_JAL};
endfunction

`endif

/* tb_rs_core.sv */
////////////////////////////////////////
// Testbench of the RV32I core
// Both memories answer one cycle late and freeze
// together with the core while stall_i is high
// The run ends on a store to DONE_ADDR
////////////////////////////////////////
`timescale 1ns/1ps

module tb_rs_core;

    `include "tb_rs_asm.svh"

    localparam rs_core_pkg::word_t RESET_PC    = rs_core_pkg::RESET_PC_DEFAULT;
    localparam rs_core_pkg::word_t MARKER_ADDR = 32'h0000_01E0;
    localparam rs_core_pkg::word_t DONE_ADDR   = 32'h0000_01F0;
    localparam rs_core_pkg::word_t LOAD_ADDR   = 32'h0000_0200;
    localparam rs_core_pkg::word_t LOAD_VAL    = 32'h0F1E_2D3C;
    localparam int                 MAX_CYCLES  = 2000;

    logic                  clk;
    logic                  rst_n_i;
    logic                  stall_i;
    rs_core_pkg::word_t    instr_i;
    rs_core_pkg::word_t    mem_rdata_i;
    rs_core_pkg::word_t    instr_addr_o;
    logic                  mem_op_en_o;
    rs_core_pkg::byte_en_t mem_we_o;
    rs_core_pkg::word_t    mem_addr_o;
    rs_core_pkg::word_t    mem_wdata_o;

    // 256 B of program, 1 KB of data
    rs_core_pkg::word_t imem [0:63];
    rs_core_pkg::word_t dmem [0:255];
    logic [5:0]         fetch_idx;
    logic [7:0]         read_idx;

    // Program builder and expected results
    rs_core_pkg::word_t prog_pc;
    rs_core_pkg::word_t rv [0:15];
    rs_core_pkg::word_t exp_addr [$];
    rs_core_pkg::word_t exp_data [$];
    logic               done_seen;
    int                 value_errs;
    int                 other_errs;
    int                 cycles;

    always #5 clk = ~clk;

    rs_core #(
        .RESET_PC(RESET_PC)
    ) UUT (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall_i),
        .instr_i     (instr_i),
        .mem_rdata_i (mem_rdata_i),
        .instr_addr_o(instr_addr_o),
        .mem_op_en_o (mem_op_en_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o)
    );

    ////////////////////////////////////////
    // Memory models
    ////////////////////////////////////////
    // Address taken on an unstalled edge
    always @(posedge clk) begin
        if (!stall_i) begin
            fetch_idx <= instr_addr_o[7:2];
        end
    end

    always @(posedge clk) begin
        if (rst_n_i && !stall_i && mem_op_en_o) begin
            if (mem_we_o != '0) begin
                assert (mem_addr_o != MARKER_ADDR) else begin
                    other_errs++;
                    $display("Store reached the marker address after a taken jump");
                end
                for (int b = 0; b < 4; b++) begin
                    if (mem_we_o[b]) begin
                        dmem[mem_addr_o[9:2]][8*b +: 8] <= mem_wdata_o[8*b +: 8];
                    end
                end
                if (mem_addr_o == DONE_ADDR) begin
                    done_seen <= 1'b1;
                end
            end else begin
                read_idx <= mem_addr_o[9:2];
            end
        end
    end

    // Responses on the falling edge
    always @(negedge clk) begin
        instr_i     <= imem[fetch_idx];
        mem_rdata_i <= dmem[read_idx];
    end

    // Random stall, about one cycle in four
    initial begin
        void'($urandom(32'h33a795e0));
        forever begin
            @(negedge clk);
            if (rst_n_i) begin
                stall_i <= (($urandom % 4) == 0);
            end else begin
                stall_i <= 1'b0;
            end
        end
    end

    // Outputs frozen in the cycle after a stalled edge
    assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> ($stable(instr_addr_o) && $stable(mem_op_en_o) && $stable(mem_we_o)
                     && $stable(mem_addr_o) && $stable(mem_wdata_o)))
        else begin
            value_errs++;
            $display("[FAIL] stall_i freeze: instr_addr_o %h mem_addr_o %h mem_wdata_o %h",
                     instr_addr_o, mem_addr_o, mem_wdata_o);
        end

    ////////////////////////////////////////
    // Program
    ////////////////////////////////////////
    task automatic emit(input rs_core_pkg::word_t instr);
        imem[prog_pc[7:2]] = instr;
        prog_pc = prog_pc + 32'd4;
    endtask

    task automatic expect_store(input rs_core_pkg::word_t addr, input rs_core_pkg::word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic load_memories();
        rs_core_pkg::word_t jal_pc;
        int                 i;
        // Unused words are x0 writes, distinct per address
        for (i = 0; i < 64; i++) begin
            imem[i] = asm_addi(5'd0, 5'd0, 12'(i));
        end
        for (i = 0; i < 256; i++) begin
            dmem[i] = 32'hD00D_0000 + 32'(i) * 32'h0001_0001;
        end
        dmem[LOAD_ADDR[9:2]] = LOAD_VAL;
        // RV32I results of the ALU block
        rv[0]  = 32'h0;
        rv[1]  = 32'h0000_0123;
        rv[2]  = 32'hFFFF_FFFB;
        rv[3]  = 32'hABCD_E000;
        rv[4]  = rv[3] + 32'h0000_0456;
        rv[5]  = rv[4] + rv[1];
        rv[6]  = rv[5] - rv[2];
        rv[7]  = rv[6] & rv[4];
        rv[8]  = rv[7] | rv[1];
        rv[9]  = rv[8] ^ rv[2];
        rv[10] = ($signed(rv[2]) < $signed(rv[1])) ? 32'd1 : 32'd0;
        rv[11] = ($signed(rv[1]) < $signed(rv[2])) ? 32'd1 : 32'd0;
        rv[13] = LOAD_VAL + rv[1];
        prog_pc = RESET_PC;
        emit(asm_addi(5'd1, 5'd0, 12'h123));
        emit(asm_addi(5'd2, 5'd0, 12'hFFB));
        emit(asm_lui(5'd3, 20'hABCDE));
        // Dependent chain through the bypass
        emit(asm_addi(5'd4, 5'd3, 12'h456));
        emit(asm_r(7'h00, 3'b000, 5'd5, 5'd4, 5'd1));
        emit(asm_r(7'h20, 3'b000, 5'd6, 5'd5, 5'd2));
        emit(asm_r(7'h00, 3'b111, 5'd7, 5'd6, 5'd4));
        emit(asm_r(7'h00, 3'b110, 5'd8, 5'd7, 5'd1));
        emit(asm_r(7'h00, 3'b100, 5'd9, 5'd8, 5'd2));
        emit(asm_r(7'h00, 3'b010, 5'd10, 5'd2, 5'd1));
        emit(asm_r(7'h00, 3'b010, 5'd11, 5'd1, 5'd2));
        for (i = 0; i < 8; i++) begin
            emit(asm_sw(5'(i + 4), 5'd0, 12'(32'h100 + 4 * i)));
            expect_store(32'h100 + 32'(4 * i), rv[i + 4]);
        end
        emit(asm_sw(5'd3, 5'd0, 12'h120));
        expect_store(32'h120, rv[3]);
        // Load-use pair
        emit(asm_lw(5'd12, 5'd0, LOAD_ADDR[11:0]));
        emit(asm_r(7'h00, 3'b000, 5'd13, 5'd12, 5'd1));
        emit(asm_sw(5'd13, 5'd0, 12'h124));
        expect_store(32'h124, rv[13]);
        emit(asm_addi(5'd0, 5'd0, 12'h7FF));
        emit(asm_sw(5'd0, 5'd0, 12'h128));
        expect_store(32'h128, rv[0]);
        // Taken jumps, each skips a marker store
        emit(asm_br(3'b000, 5'd1, 5'd1, 13'd8));
        emit(asm_sw(5'd1, 5'd0, MARKER_ADDR[11:0]));
        emit(asm_br(3'b001, 5'd1, 5'd2, 13'd8));
        emit(asm_sw(5'd1, 5'd0, MARKER_ADDR[11:0]));
        jal_pc = prog_pc;
        emit(asm_jal(5'd14, 21'd8));
        emit(asm_sw(5'd1, 5'd0, MARKER_ADDR[11:0]));
        emit(asm_sw(5'd14, 5'd0, 12'h12C));
        expect_store(32'h12C, jal_pc + 32'd4);
        // Not taken, the store after it must land
        emit(asm_br(3'b000, 5'd1, 5'd2, 13'd8));
        emit(asm_sw(5'd1, 5'd0, 12'h130));
        expect_store(32'h130, rv[1]);
        emit(asm_sw(5'd1, 5'd0, DONE_ADDR[11:0]));
        emit(asm_jal(5'd0, 21'd0));
    endtask

    task automatic check_stores();
        rs_core_pkg::word_t addr;
        rs_core_pkg::word_t got;
        int                 k;
        for (k = 0; k < exp_addr.size(); k++) begin
            addr = exp_addr[k];
            got  = dmem[addr[9:2]];
            assert (got == exp_data[k]) else begin
                value_errs++;
                $display("[FAIL] dmem[%h] got %h expected %h", addr, got, exp_data[k]);
            end
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        stall_i     = 1'b0;
        instr_i     = '0;
        mem_rdata_i = '0;
        fetch_idx   = '0;
        read_idx    = '0;
        done_seen   = 1'b0;
        value_errs  = 0;
        other_errs  = 0;
        load_memories();
        repeat (2) @(negedge clk);
        rst_n_i <= 1'b1;
        // First cycle out of reset
        assert (instr_addr_o == RESET_PC) else begin
            value_errs++;
            $display("[FAIL] instr_addr_o got %h expected %h", instr_addr_o, RESET_PC);
        end
        assert (!mem_op_en_o && mem_we_o == '0) else begin
            value_errs++;
            $display("[FAIL] mem_op_en_o %h mem_we_o %h expected 0", mem_op_en_o, mem_we_o);
        end
        cycles = 0;
        while (!done_seen && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!done_seen) begin
            other_errs++;
            $display("Timeout, no store to the done address in %0d cycles", MAX_CYCLES);
        end
        check_stores();
        $display("Errors: value %0d, other %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* rs_core.sv */
////////////////////////////////////////
// Top of the in-order RV32I core
// Memories answer one cycle after the request
// stall_i freezes every register in the core
////////////////////////////////////////
`timescale 1ns/1ps

module rs_core #(
    parameter rs_core_pkg::word_t RESET_PC = rs_core_pkg::RESET_PC_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  rs_core_pkg::word_t    instr_i,
    input  rs_core_pkg::word_t    mem_rdata_i,
    output rs_core_pkg::word_t    instr_addr_o,
    output logic                  mem_op_en_o,
    output rs_core_pkg::byte_en_t mem_we_o,
    output rs_core_pkg::word_t    mem_addr_o,
    output rs_core_pkg::word_t    mem_wdata_o
);

    ////////////////////////////////////////
    // Pipeline control
    ////////////////////////////////////////
    logic                   jump;
    rs_core_pkg::word_t     jump_target;
    logic                   hold;
    logic                   hazard;
    logic                   load_wb;

    // Decode side
    rs_core_pkg::word_t     pc_fetch;
    rs_core_pkg::reg_addr_t rs1;
    rs_core_pkg::reg_addr_t rs2;
    rs_core_pkg::word_t     rs1_data;
    rs_core_pkg::word_t     rs2_data;

    // Execute register contents
    rs_core_pkg::op_e       op_ex;
    rs_core_pkg::reg_addr_t rd_ex;
    rs_core_pkg::word_t     opa_ex;
    rs_core_pkg::word_t     opb_ex;
    rs_core_pkg::word_t     imm_ex;
    rs_core_pkg::word_t     pc_ex;

    // Write-back
    logic                   wb_en;
    rs_core_pkg::reg_addr_t wb_rd;
    rs_core_pkg::word_t     wb_data;

    rs_fetch #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_i),
        .hold_i       (hold),
        .hazard_i     (hazard),
        .jump_i       (jump),
        .jump_target_i(jump_target),
        .instr_addr_o (instr_addr_o),
        .pc_o         (pc_fetch)
    );

    rs_decode u_decode (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .stall_i   (stall_i),
        .hold_i    (hold),
        .jump_i    (jump),
        .instr_i   (instr_i),
        .pc_i      (pc_fetch),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .rs1_o     (rs1),
        .rs2_o     (rs2),
        .hazard_o  (hazard),
        .op_o      (op_ex),
        .rd_o      (rd_ex),
        .opa_o     (opa_ex),
        .opb_o     (opb_ex),
        .imm_o     (imm_ex),
        .pc_o      (pc_ex)
    );

    rs_regbank u_regbank (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .rs1_i  (rs1),
        .rs2_i  (rs2),
        .we_i   (wb_en),
        .rd_i   (wb_rd),
        .data_i (wb_data),
        .data1_o(rs1_data),
        .data2_o(rs2_data)
    );

    rs_exec_ctrl u_exec_ctrl (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .stall_i  (stall_i),
        .op_i     (op_ex),
        .hold_o   (hold),
        .load_wb_o(load_wb)
    );

    rs_execute u_execute (
        .stall_i      (stall_i),
        .load_wb_i    (load_wb),
        .op_i         (op_ex),
        .rd_i         (rd_ex),
        .opa_i        (opa_ex),
        .opb_i        (opb_ex),
        .imm_i        (imm_ex),
        .pc_i         (pc_ex),
        .mem_rdata_i  (mem_rdata_i),
        .jump_o       (jump),
        .jump_target_o(jump_target),
        .wb_en_o      (wb_en),
        .wb_rd_o      (wb_rd),
        .wb_data_o    (wb_data),
        .mem_op_en_o  (mem_op_en_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o)
    );

endmodule

/* rs_execute.sv */
////////////////////////////////////////
// Execute and retire, fully combinational
// Branches resolve here, younger words are killed in decode
// Memory outputs stay steady under stall, jump and
// write-back do not fire
////////////////////////////////////////
`timescale 1ns/1ps

module rs_execute (
    input  logic                   stall_i,
    input  logic                   load_wb_i,
    input  rs_core_pkg::op_e       op_i,
    input  rs_core_pkg::reg_addr_t rd_i,
    input  rs_core_pkg::word_t     opa_i,
    input  rs_core_pkg::word_t     opb_i,
    input  rs_core_pkg::word_t     imm_i,
    input  rs_core_pkg::word_t     pc_i,
    input  rs_core_pkg::word_t     mem_rdata_i,
    output logic                   jump_o,
    output rs_core_pkg::word_t     jump_target_o,
    output logic                   wb_en_o,
    output rs_core_pkg::reg_addr_t wb_rd_o,
    output rs_core_pkg::word_t     wb_data_o,
    output logic                   mem_op_en_o,
    output rs_core_pkg::byte_en_t  mem_we_o,
    output rs_core_pkg::word_t     mem_addr_o,
    output rs_core_pkg::word_t     mem_wdata_o
);

    rs_core_pkg::word_t alu_res;
    logic               taken;
    logic               writes_rd;

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////
    always_comb begin
        writes_rd = 1'b1;
        case (op_i)
            rs_core_pkg::OP_ADD: alu_res = opa_i + opb_i;
            rs_core_pkg::OP_SUB: alu_res = opa_i - opb_i;
            rs_core_pkg::OP_AND: alu_res = opa_i & opb_i;
            rs_core_pkg::OP_OR:  alu_res = opa_i | opb_i;
            rs_core_pkg::OP_XOR: alu_res = opa_i ^ opb_i;
            rs_core_pkg::OP_SLT: alu_res = {31'b0, $signed(opa_i) < $signed(opb_i)};
            rs_core_pkg::OP_LUI: alu_res = imm_i;
            // Link address
            rs_core_pkg::OP_JAL: alu_res = pc_i + 32'd4;
            default: begin
                alu_res   = '0;
                writes_rd = 1'b0;
            end
        endcase
    end

    // Branch decision
    always_comb begin
        case (op_i)
            rs_core_pkg::OP_BEQ: taken = (opa_i == opb_i);
            rs_core_pkg::OP_BNE: taken = (opa_i != opb_i);
            rs_core_pkg::OP_JAL: taken = 1'b1;
            default:             taken = 1'b0;
        endcase
    end

    assign jump_o        = taken && !stall_i;
    assign jump_target_o = pc_i + imm_i;

    ////////////////////////////////////////
    // Data memory request
    ////////////////////////////////////////
    // LW requests only in its first cycle
    assign mem_op_en_o = (op_i == rs_core_pkg::OP_SW)
                         || (op_i == rs_core_pkg::OP_LW && !load_wb_i);
    assign mem_we_o    = (op_i == rs_core_pkg::OP_SW) ? '1 : '0;
    assign mem_addr_o  = opa_i + imm_i;
    assign mem_wdata_o = opb_i;

    // Retire, load data in the wait cycle
    assign wb_en_o   = !stall_i && (rd_i != '0) && (writes_rd || load_wb_i);
    assign wb_rd_o   = rd_i;
    assign wb_data_o = load_wb_i ? mem_rdata_i : alu_res;

endmodule

/* rs_exec_ctrl.sv */
////////////////////////////////////////
// Load-wait controller of the execute stage
// LW occupies execute for two unstalled cycles
////////////////////////////////////////
`timescale 1ns/1ps

module rs_exec_ctrl (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             stall_i,
    input  rs_core_pkg::op_e op_i,
    output logic             hold_o,
    output logic             load_wb_o
);

    rs_core_pkg::exec_state_e state_q;
    rs_core_pkg::exec_state_e state_d;

    always_comb begin
        state_d   = state_q;
        hold_o    = 1'b0;
        load_wb_o = 1'b0;
        case (state_q)
            // Request issued, freeze the front end
            rs_core_pkg::EX_RUN: begin
                if (op_i == rs_core_pkg::OP_LW) begin
                    hold_o  = 1'b1;
                    state_d = rs_core_pkg::EX_LOAD_WAIT;
                end
            end
            // Read data on the bus now
            rs_core_pkg::EX_LOAD_WAIT: begin
                load_wb_o = 1'b1;
                state_d   = rs_core_pkg::EX_RUN;
            end
            default: state_d = rs_core_pkg::EX_RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= rs_core_pkg::EX_RUN;
        end else if (!stall_i) begin
            state_q <= state_d;
        end
    end

    // Wait cycle only ever belongs to the LW still held in execute
    assert property (@(posedge clk) disable iff (!rst_n_i)
        state_q == rs_core_pkg::EX_LOAD_WAIT |-> op_i == rs_core_pkg::OP_LW)
        else $error("load wait without LW in execute");

endmodule

/* rs_regbank.sv */
////////////////////////////////////////
// Register bank, x1 to x31 in flip-flops
// x0 reads zero and drops writes
// Same-cycle write is forwarded to the readers
////////////////////////////////////////
`timescale 1ns/1ps

module rs_regbank (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  rs_core_pkg::reg_addr_t rs1_i,
    input  rs_core_pkg::reg_addr_t rs2_i,
    input  logic                   we_i,
    input  rs_core_pkg::reg_addr_t rd_i,
    input  rs_core_pkg::word_t     data_i,
    output rs_core_pkg::word_t     data1_o,
    output rs_core_pkg::word_t     data2_o
);

    rs_core_pkg::word_t regs_q [31:1];
    logic               wr_valid;

    assign wr_valid = we_i && (rd_i != '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_valid) begin
            regs_q[rd_i] <= data_i;
        end
    end

    // Read ports with write-back bypass
    assign data1_o = (wr_valid && rs1_i == rd_i) ? data_i
                   : (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign data2_o = (wr_valid && rs2_i == rd_i) ? data_i
                   : (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

/* rs_decode.sv */
////////////////////////////////////////
// Decode stage and decode-to-execute register
// Unsupported encodings enter execute as OP_NOP
// Two words after a jump are killed, and the first word
// after reset is dropped as well
////////////////////////////////////////
`timescale 1ns/1ps

module rs_decode (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   stall_i,
    input  logic                   hold_i,
    input  logic                   jump_i,
    input  rs_core_pkg::word_t     instr_i,
    input  rs_core_pkg::word_t     pc_i,
    input  rs_core_pkg::word_t     rs1_data_i,
    input  rs_core_pkg::word_t     rs2_data_i,
    output rs_core_pkg::reg_addr_t rs1_o,
    output rs_core_pkg::reg_addr_t rs2_o,
    output logic                   hazard_o,
    output rs_core_pkg::op_e       op_o,
    output rs_core_pkg::reg_addr_t rd_o,
    output rs_core_pkg::word_t     opa_o,
    output rs_core_pkg::word_t     opb_o,
    output rs_core_pkg::word_t     imm_o,
    output rs_core_pkg::word_t     pc_o
);

    rs_core_pkg::opcode_e   opcode;
    rs_core_pkg::op_e       op_dec;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    rs_core_pkg::word_t     imm_itype;
    rs_core_pkg::word_t     imm_stype;
    rs_core_pkg::word_t     imm_btype;
    rs_core_pkg::word_t     imm_utype;
    rs_core_pkg::word_t     imm_jtype;
    rs_core_pkg::word_t     imm_sel;
    logic                   use_rs1;
    logic                   use_rs2;
    logic                   use_imm;
    logic                   kill_q;

    // Sources of the word that entered execute
    rs_core_pkg::reg_addr_t ex_rs1_q;
    rs_core_pkg::reg_addr_t ex_rs2_q;
    logic                   ex_use_rs1_q;
    logic                   ex_use_rs2_q;

    ////////////////////////////////////////
    // Fields and immediates
    ////////////////////////////////////////
    assign opcode = rs_core_pkg::opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];

    assign imm_itype = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_stype = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_btype = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_utype = {instr_i[31:12], 12'b0};
    assign imm_jtype = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                        instr_i[20], instr_i[30:21], 1'b0};

    // Operation select
    always_comb begin
        op_dec  = rs_core_pkg::OP_NOP;
        imm_sel = imm_itype;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_imm = 1'b0;
        case (opcode)
            rs_core_pkg::OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: op_dec = rs_core_pkg::OP_ADD;
                    {7'h20, 3'b000}: op_dec = rs_core_pkg::OP_SUB;
                    {7'h00, 3'b111}: op_dec = rs_core_pkg::OP_AND;
                    {7'h00, 3'b110}: op_dec = rs_core_pkg::OP_OR;
                    {7'h00, 3'b100}: op_dec = rs_core_pkg::OP_XOR;
                    {7'h00, 3'b010}: op_dec = rs_core_pkg::OP_SLT;
                    default:         op_dec = rs_core_pkg::OP_NOP;
                endcase
            end
            // ADDI only, immediate replaces rs2
            rs_core_pkg::OPC_OP_IMM: begin
                use_rs1 = 1'b1;
                use_imm = 1'b1;
                if (funct3 == 3'b000) begin
                    op_dec = rs_core_pkg::OP_ADD;
                end
            end
            rs_core_pkg::OPC_LUI: begin
                op_dec  = rs_core_pkg::OP_LUI;
                imm_sel = imm_utype;
            end
            rs_core_pkg::OPC_LOAD: begin
                use_rs1 = 1'b1;
                if (funct3 == 3'b010) begin
                    op_dec = rs_core_pkg::OP_LW;
                end
            end
            rs_core_pkg::OPC_STORE: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm_sel = imm_stype;
                if (funct3 == 3'b010) begin
                    op_dec = rs_core_pkg::OP_SW;
                end
            end
            rs_core_pkg::OPC_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm_sel = imm_btype;
                if (funct3 == 3'b000) begin
                    op_dec = rs_core_pkg::OP_BEQ;
                end else if (funct3 == 3'b001) begin
                    op_dec = rs_core_pkg::OP_BNE;
                end
            end
            rs_core_pkg::OPC_JAL: begin
                op_dec  = rs_core_pkg::OP_JAL;
                imm_sel = imm_jtype;
            end
            default: op_dec = rs_core_pkg::OP_NOP;
        endcase
    end

    // Load-use conflict with the word in execute
    assign hazard_o = (op_o == rs_core_pkg::OP_LW) && (rd_o != '0)
                      && ((use_rs1 && rs1_o == rd_o) || (use_rs2 && rs2_o == rd_o));

    ////////////////////////////////////////
    // Execute register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            op_o   <= rs_core_pkg::OP_NOP;
            kill_q <= 1'b1;
        end else if (!stall_i) begin
            // Second word of the kill window
            kill_q <= jump_i;
            if (!hold_i) begin
                if (jump_i || kill_q || hazard_o) begin
                    op_o <= rs_core_pkg::OP_NOP;
                end else begin
                    op_o <= op_dec;
                end
            end
        end
    end

    // Payload, only meaningful alongside op_o
    always_ff @(posedge clk) begin
        if (!stall_i && !hold_i) begin
            rd_o         <= instr_i[11:7];
            opa_o        <= rs1_data_i;
            opb_o        <= use_imm ? imm_sel : rs2_data_i;
            imm_o        <= imm_sel;
            pc_o         <= pc_i;
            ex_rs1_q     <= rs1_o;
            ex_rs2_q     <= rs2_o;
            ex_use_rs1_q <= use_rs1;
            ex_use_rs2_q <= use_rs2;
        end
    end

    // The word behind a LW never reads the register the LW is loading
    assert property (@(posedge clk) disable iff (!rst_n_i)
        ($past(op_o) == rs_core_pkg::OP_LW && $past(rd_o) != '0
         && $past(!stall_i && !hold_i) && op_o != rs_core_pkg::OP_NOP)
        |-> !((ex_use_rs1_q && ex_rs1_q == $past(rd_o))
              || (ex_use_rs2_q && ex_rs2_q == $past(rd_o))))
        else $error("load-use word entered execute behind LW");

endmodule

/* rs_fetch.sv */
////////////////////////////////////////
// Program counter of the core
// Instruction memory answers one cycle after the address
// On hold or hazard the address of the pending word is
// driven again, so it arrives once more in the next cycle
////////////////////////////////////////
`timescale 1ns/1ps

module rs_fetch #(
    parameter rs_core_pkg::word_t RESET_PC = rs_core_pkg::RESET_PC_DEFAULT
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               stall_i,
    input  logic               hold_i,
    input  logic               hazard_i,
    input  logic               jump_i,
    input  rs_core_pkg::word_t jump_target_i,
    output rs_core_pkg::word_t instr_addr_o,
    output rs_core_pkg::word_t pc_o
);

    // Next address to fetch
    rs_core_pkg::word_t pc_q;
    logic               refetch;

    // Decode cannot take the word now, ask for it again
    assign refetch      = hold_i | hazard_i;
    assign instr_addr_o = refetch ? pc_o : pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
            pc_o <= RESET_PC;
        end else if (!stall_i) begin
            // Address of the word returned next cycle
            pc_o <= instr_addr_o;
            if (jump_i) begin
                pc_q <= jump_target_i;
            end else if (!refetch) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    // Fetch never leaves word alignment
    assert property (@(posedge clk) disable iff (!rst_n_i)
        instr_addr_o[1:0] == 2'b00)
        else $error("fetch address misaligned: %h", instr_addr_o);

endmodule

/* rs_core_pkg.sv */
////////////////////////////////////////
// Shared types and encodings of the RV32I core
// Only the opcodes that the core executes are listed
// Unlisted encodings decode to OP_NOP
////////////////////////////////////////

package rs_core_pkg;

    // Data, address and instruction word
    typedef logic [31:0] word_t;

    // Register index
    typedef logic [4:0] reg_addr_t;

    // Store byte lanes
    typedef logic [3:0] byte_en_t;

    // Reset fetch address
    localparam word_t RESET_PC_DEFAULT = 32'h0000_0000;

    ////////////////////////////////////////
    // Major opcodes, bits 6:0
    ////////////////////////////////////////
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // Execute operations
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_JAL
    } op_e;

    // Load-wait controller states
    typedef enum logic {
        EX_RUN,
        EX_LOAD_WAIT
    } exec_state_e;

endpackage
